// ==== host_domain_cfg.svh ====
// Counter count, bus widths and the register map are fixed here; the map assumes word-aligned offsets
`ifndef HOST_DOMAIN_CFG_SVH
`define HOST_DOMAIN_CFG_SVH

// Event counters and their width
`define HD_NUM_COUNTERS 5
`define HD_CNT_WIDTH 32

// Config port widths
`define HD_LITE_AW 32
`define HD_LITE_DW 32

// Counter index of each event source
`define HD_EVT_RD_HIT 0
`define HD_EVT_RD_MISS 1
`define HD_EVT_WR_HIT 2
`define HD_EVT_WR_MISS 3
`define HD_EVT_DMA 4

// Register map, counter i at base plus 4*i
`define HD_REG_CNT_BASE 32'h0000_0000
`define HD_REG_ENABLE 32'h0000_0020
`define HD_REG_IRQ_STATUS 32'h0000_0024
`define HD_UNMAPPED_RDATA 32'hdeadf000

// Response codes
`define HD_RESP_OKAY 2'b00
`define HD_RESP_SLVERR 2'b10

`endif

// ==== host_domain_pkg.sv ====
// Shared types of the host-domain slice; widths follow host_domain_cfg.svh and are not parameters

`include "host_domain_cfg.svh"

package host_domain_pkg;

  // One performance counter value
  typedef logic [`HD_CNT_WIDTH-1:0] cnt_t;

  // One bit per counter: events, enable mask, overflow status, strobes
  typedef logic [`HD_NUM_COUNTERS-1:0] evt_vec_t;

  // Config port address, data and response
  typedef logic [`HD_LITE_AW-1:0] lite_addr_t;
  typedef logic [`HD_LITE_DW-1:0] lite_data_t;
  typedef logic [1:0] lite_resp_t;

  // Kind of register an address decodes to
  typedef enum logic [1:0] {
    REG_COUNTER,
    REG_ENABLE,
    REG_IRQ_STATUS,
    REG_UNMAPPED
  } reg_kind_e;

endpackage

// ==== rst_sync.sv ====
// Reset asserts asynchronously and releases on the second clk_i edge; rst_n_i needs no timing to clk_i

module rst_sync (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);

  // Ones shift in after release, zeros on assert
  logic [1:0] sync_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_n_o = sync_q[1];

endmodule

// ==== edge_propagator_rx.sv ====
// Expects a four-phase level handshake on valid_i; a new request must wait for ack_o to fall

module edge_propagator_rx (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ack_o,
  output logic valid_o
);

  // Two-flop synchronizer for the cluster level
  logic sync1_q;
  logic sync2_q;

  // Previous acknowledge, for rising-edge detection
  logic ack_prev_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q <= 1'b0;
      sync2_q <= 1'b0;
    end else begin
      sync1_q <= valid_i;
      sync2_q <= sync1_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_prev_q <= 1'b0;
    end else begin
      ack_prev_q <= sync2_q;
    end
  end

  // Synchronized level doubles as the acknowledge
  assign ack_o = sync2_q;

  // One pulse per handshake, on the first cycle of ack high
  assign valid_o = sync2_q & ~ack_prev_q;

endmodule

// ==== pmu_counters.sv ====
// Counters wrap silently apart from the sticky status bit; a load beats an increment in the same cycle

`include "host_domain_cfg.svh"

module pmu_counters (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  host_domain_pkg::evt_vec_t                        evt_i,
  input  host_domain_pkg::evt_vec_t                        cnt_wr_i,
  input  logic                                             en_wr_i,
  input  host_domain_pkg::evt_vec_t                        irq_clr_i,
  input  host_domain_pkg::cnt_t                            wr_data_i,
  output host_domain_pkg::cnt_t [`HD_NUM_COUNTERS-1:0]     cnt_o,
  output host_domain_pkg::evt_vec_t                        enable_o,
  output host_domain_pkg::evt_vec_t                        ovf_status_o,
  output logic                                             irq_o
);

  import host_domain_pkg::*;

  cnt_t [`HD_NUM_COUNTERS-1:0] cnt_q;
  cnt_t [`HD_NUM_COUNTERS-1:0] cnt_d;
  evt_vec_t                    enable_q;
  evt_vec_t                    status_q;
  evt_vec_t                    status_d;

  // Per-counter increment and wrap
  evt_vec_t                    inc;
  evt_vec_t                    wrap;

  always_comb begin
    for (int i = 0; i < `HD_NUM_COUNTERS; i++) begin
      inc[i]  = evt_i[i] & enable_q[i];
      // A load in the same cycle cancels the increment, so no wrap either
      wrap[i] = inc[i] & ~cnt_wr_i[i] & (cnt_q[i] == '1);
      if (cnt_wr_i[i]) begin
        cnt_d[i] = wr_data_i;
      end else if (inc[i]) begin
        cnt_d[i] = cnt_q[i] + cnt_t'(1);
      end else begin
        cnt_d[i] = cnt_q[i];
      end
    end
  end

  // Set wins over clear on the same bit
  assign status_d = (status_q & ~irq_clr_i) | wrap;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= '0;
    end else if (en_wr_i) begin
      enable_q <= wr_data_i[`HD_NUM_COUNTERS-1:0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      status_q <= '0;
    end else begin
      status_q <= status_d;
    end
  end

  assign cnt_o        = cnt_q;
  assign enable_o     = enable_q;
  assign ovf_status_o = status_q;

  // Any sticky overflow raises the interrupt
  assign irq_o = |status_q;

endmodule

// ==== lite_cfg_port.sv ====
// AW and W must arrive in the same cycle; no IDs, bursts or byte strobes, one transfer per channel

`include "host_domain_cfg.svh"

module lite_cfg_port (
  input  logic                                         clk_i,
  input  logic                                         rst_n_i,
  input  logic                                         aw_valid_i,
  output logic                                         aw_ready_o,
  input  host_domain_pkg::lite_addr_t                  aw_addr_i,
  input  logic                                         w_valid_i,
  output logic                                         w_ready_o,
  input  host_domain_pkg::lite_data_t                  w_data_i,
  output logic                                         b_valid_o,
  input  logic                                         b_ready_i,
  output host_domain_pkg::lite_resp_t                  b_resp_o,
  input  logic                                         ar_valid_i,
  output logic                                         ar_ready_o,
  input  host_domain_pkg::lite_addr_t                  ar_addr_i,
  output logic                                         r_valid_o,
  input  logic                                         r_ready_i,
  output host_domain_pkg::lite_data_t                  r_data_o,
  output host_domain_pkg::lite_resp_t                  r_resp_o,
  output host_domain_pkg::evt_vec_t                    cnt_wr_o,
  output logic                                         en_wr_o,
  output host_domain_pkg::evt_vec_t                    irq_clr_o,
  output host_domain_pkg::cnt_t                        wr_data_o,
  input  host_domain_pkg::cnt_t [`HD_NUM_COUNTERS-1:0] cnt_i,
  input  host_domain_pkg::evt_vec_t                    enable_i,
  input  host_domain_pkg::evt_vec_t                    ovf_status_i
);

  import host_domain_pkg::*;

  // Counter index width
  localparam int unsigned IDX_W = $clog2(`HD_NUM_COUNTERS);

  function automatic reg_kind_e decode_kind(lite_addr_t addr);
    lite_addr_t offset;
    offset = addr - lite_addr_t'(`HD_REG_CNT_BASE);
    if (offset < lite_addr_t'(4 * `HD_NUM_COUNTERS) && offset[1:0] == 2'b00) begin
      return REG_COUNTER;
    end else if (addr == lite_addr_t'(`HD_REG_ENABLE)) begin
      return REG_ENABLE;
    end else if (addr == lite_addr_t'(`HD_REG_IRQ_STATUS)) begin
      return REG_IRQ_STATUS;
    end
    return REG_UNMAPPED;
  endfunction

  // Only meaningful when the kind is REG_COUNTER
  function automatic logic [IDX_W-1:0] decode_idx(lite_addr_t addr);
    lite_addr_t offset;
    offset = addr - lite_addr_t'(`HD_REG_CNT_BASE);
    return offset[IDX_W+1:2];
  endfunction

  logic             b_valid_q;
  lite_resp_t       b_resp_q;
  logic             r_valid_q;
  lite_data_t       r_data_q;
  lite_resp_t       r_resp_q;

  logic             wr_fire;
  reg_kind_e        wr_kind;
  logic [IDX_W-1:0] wr_idx;
  logic             rd_fire;
  reg_kind_e        rd_kind;
  logic [IDX_W-1:0] rd_idx;
  lite_data_t       rd_data;

  assign wr_kind = decode_kind(aw_addr_i);
  assign wr_idx  = decode_idx(aw_addr_i);
  assign rd_kind = decode_kind(ar_addr_i);
  assign rd_idx  = decode_idx(ar_addr_i);

  // Back-pressure: no new request while a response waits
  assign aw_ready_o = ~b_valid_q;
  assign w_ready_o  = ~b_valid_q;
  assign ar_ready_o = ~r_valid_q;

  assign wr_fire = aw_valid_i & w_valid_i & ~b_valid_q;
  assign rd_fire = ar_valid_i & ~r_valid_q;

  // One strobe per accepted write, none for unmapped
  assign cnt_wr_o  = (wr_fire && wr_kind == REG_COUNTER) ? (evt_vec_t'(1) << wr_idx) : '0;
  assign en_wr_o   = wr_fire && wr_kind == REG_ENABLE;
  assign irq_clr_o = (wr_fire && wr_kind == REG_IRQ_STATUS) ?
                     w_data_i[`HD_NUM_COUNTERS-1:0] : '0;
  assign wr_data_o = cnt_t'(w_data_i);

  always_comb begin
    case (rd_kind)
      REG_COUNTER:    rd_data = lite_data_t'(cnt_i[rd_idx]);
      REG_ENABLE:     rd_data = lite_data_t'(enable_i);
      REG_IRQ_STATUS: rd_data = lite_data_t'(ovf_status_i);
      default:        rd_data = `HD_UNMAPPED_RDATA;
    endcase
  end

  // Write response
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_fire) begin
      b_valid_q <= 1'b1;
    end else if (b_ready_i) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      b_resp_q <= (wr_kind == REG_UNMAPPED) ? `HD_RESP_SLVERR : `HD_RESP_OKAY;
    end
  end

  // Read response, data taken before same-edge increments
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_fire) begin
      r_valid_q <= 1'b1;
    end else if (r_ready_i) begin
      r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      r_data_q <= rd_data;
      r_resp_q <= (rd_kind == REG_UNMAPPED) ? `HD_RESP_SLVERR : `HD_RESP_OKAY;
    end
  end

  assign b_valid_o = b_valid_q;
  assign b_resp_o  = b_resp_q;
  assign r_valid_o = r_valid_q;
  assign r_data_o  = r_data_q;
  assign r_resp_o  = r_resp_q;

endmodule

// ==== host_domain.sv ====
// Single clock domain only; LLC events are plain levels counted once per cycle while high

`include "host_domain_cfg.svh"

module host_domain (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        llc_read_hit_i,
  input  logic                        llc_read_miss_i,
  input  logic                        llc_write_hit_i,
  input  logic                        llc_write_miss_i,
  input  logic                        dma_pe_evt_valid_i,
  output logic                        dma_pe_evt_ack_o,
  output logic                        dma_pe_evt_o,
  output logic                        pmu_irq_o,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  host_domain_pkg::lite_addr_t aw_addr_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  host_domain_pkg::lite_data_t w_data_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output host_domain_pkg::lite_resp_t b_resp_o,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  host_domain_pkg::lite_addr_t ar_addr_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output host_domain_pkg::lite_data_t r_data_o,
  output host_domain_pkg::lite_resp_t r_resp_o
);

  import host_domain_pkg::*;

  logic                        sys_rst_n;
  logic                        dma_evt;
  evt_vec_t                    evt;
  evt_vec_t                    cnt_wr;
  logic                        en_wr;
  evt_vec_t                    irq_clr;
  cnt_t                        wr_data;
  cnt_t [`HD_NUM_COUNTERS-1:0] cnt;
  evt_vec_t                    enable;
  evt_vec_t                    ovf_status;

  rst_sync i_rst_sync (
    .clk_i   ( clk_i     ),
    .rst_n_i ( rst_n_i   ),
    .rst_n_o ( sys_rst_n )
  );

  edge_propagator_rx i_ep_dma_pe_evt (
    .clk_i   ( clk_i              ),
    .rst_n_i ( sys_rst_n          ),
    .valid_i ( dma_pe_evt_valid_i ),
    .ack_o   ( dma_pe_evt_ack_o   ),
    .valid_o ( dma_evt            )
  );

  assign dma_pe_evt_o = dma_evt;

  // Event vector in counter order
  always_comb begin
    evt                  = '0;
    evt[`HD_EVT_RD_HIT]  = llc_read_hit_i;
    evt[`HD_EVT_RD_MISS] = llc_read_miss_i;
    evt[`HD_EVT_WR_HIT]  = llc_write_hit_i;
    evt[`HD_EVT_WR_MISS] = llc_write_miss_i;
    evt[`HD_EVT_DMA]     = dma_evt;
  end

  pmu_counters i_pmu_counters (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( sys_rst_n  ),
    .evt_i        ( evt        ),
    .cnt_wr_i     ( cnt_wr     ),
    .en_wr_i      ( en_wr      ),
    .irq_clr_i    ( irq_clr    ),
    .wr_data_i    ( wr_data    ),
    .cnt_o        ( cnt        ),
    .enable_o     ( enable     ),
    .ovf_status_o ( ovf_status ),
    .irq_o        ( pmu_irq_o  )
  );

  lite_cfg_port i_lite_cfg_port (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( sys_rst_n  ),
    .aw_valid_i   ( aw_valid_i ),
    .aw_ready_o   ( aw_ready_o ),
    .aw_addr_i    ( aw_addr_i  ),
    .w_valid_i    ( w_valid_i  ),
    .w_ready_o    ( w_ready_o  ),
    .w_data_i     ( w_data_i   ),
    .b_valid_o    ( b_valid_o  ),
    .b_ready_i    ( b_ready_i  ),
    .b_resp_o     ( b_resp_o   ),
    .ar_valid_i   ( ar_valid_i ),
    .ar_ready_o   ( ar_ready_o ),
    .ar_addr_i    ( ar_addr_i  ),
    .r_valid_o    ( r_valid_o  ),
    .r_ready_i    ( r_ready_i  ),
    .r_data_o     ( r_data_o   ),
    .r_resp_o     ( r_resp_o   ),
    .cnt_wr_o     ( cnt_wr     ),
    .en_wr_o      ( en_wr      ),
    .irq_clr_o    ( irq_clr    ),
    .wr_data_o    ( wr_data    ),
    .cnt_i        ( cnt        ),
    .enable_i     ( enable     ),
    .ovf_status_i ( ovf_status )
  );

endmodule

// ==== host_domain_tb.sv ====
// Directed tests with a fixed seed; register offsets, response codes and reset values follow host_domain_cfg.svh

`include "host_domain_cfg.svh"

module host_domain_tb;

  import host_domain_pkg::*;

  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 10;
  localparam int EVT_CYCLES  = 200;
  localparam int NUM_DMA_HS  = 8;
  localparam int NUM_BUS_OPS = 34;

  // Upper bounds in cycles for one bus operation and one DMA handshake
  localparam int BUS_OP_CYCLES   = 8;
  localparam int DMA_HS_CYCLES   = 10;
  localparam int WATCHDOG_CYCLES = RST_CYCLES + EVT_CYCLES + NUM_BUS_OPS * BUS_OP_CYCLES +
                                   NUM_DMA_HS * DMA_HS_CYCLES + 100;

  logic       clk_i;
  logic       rst_n_i;
  logic       llc_read_hit_i;
  logic       llc_read_miss_i;
  logic       llc_write_hit_i;
  logic       llc_write_miss_i;
  logic       dma_pe_evt_valid_i;
  logic       dma_pe_evt_ack_o;
  logic       dma_pe_evt_o;
  logic       pmu_irq_o;
  logic       aw_valid_i;
  logic       aw_ready_o;
  lite_addr_t aw_addr_i;
  logic       w_valid_i;
  logic       w_ready_o;
  lite_data_t w_data_i;
  logic       b_valid_o;
  logic       b_ready_i;
  lite_resp_t b_resp_o;
  logic       ar_valid_i;
  logic       ar_ready_o;
  lite_addr_t ar_addr_i;
  logic       r_valid_o;
  logic       r_ready_i;
  lite_data_t r_data_o;
  lite_resp_t r_resp_o;

  integer     seed;
  int         pulse_cnt;
  // Model of the register contents
  cnt_t       exp_cnt [`HD_NUM_COUNTERS];
  evt_vec_t   exp_en;

  host_domain host_domain_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Pulses on the DMA event output
  always @(negedge clk_i) begin
    if (dma_pe_evt_o) begin
      pulse_cnt <= pulse_cnt + 1;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    abort_run("watchdog expired, a handshake never completed");
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error at %0t: %s got 0x%08h, expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  function automatic lite_addr_t cnt_addr(input int idx);
    return lite_addr_t'(`HD_REG_CNT_BASE + 4 * idx);
  endfunction

  // Present AW and W together and hold them until accepted
  task automatic send_write(input lite_addr_t addr, input lite_data_t data);
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_addr_i  <= addr;
    w_valid_i  <= 1'b1;
    w_data_i   <= data;
    @(negedge clk_i);
    while (!(aw_ready_o && w_ready_o)) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
  endtask

  task automatic wait_bresp(input lite_resp_t exp_resp);
    @(negedge clk_i);
    while (!b_valid_o) begin
      @(negedge clk_i);
    end
    check_eq("b_resp_o", 32'(b_resp_o), 32'(exp_resp));
    @(posedge clk_i);
  endtask

  task automatic cfg_write(input lite_addr_t addr, input lite_data_t data,
                           input lite_resp_t exp_resp);
    send_write(addr, data);
    wait_bresp(exp_resp);
  endtask

  task automatic cfg_read(input lite_addr_t addr, input lite_data_t exp_data,
                          input lite_resp_t exp_resp);
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_addr_i  <= addr;
    @(negedge clk_i);
    while (!ar_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    @(negedge clk_i);
    while (!r_valid_o) begin
      @(negedge clk_i);
    end
    check_eq("r_data_o", r_data_o, exp_data);
    check_eq("r_resp_o", 32'(r_resp_o), 32'(exp_resp));
    @(posedge clk_i);
  endtask

  task automatic check_all_regs(input evt_vec_t exp_status);
    for (int i = 0; i < `HD_NUM_COUNTERS; i++) begin
      cfg_read(cnt_addr(i), exp_cnt[i], `HD_RESP_OKAY);
    end
    cfg_read(`HD_REG_ENABLE, 32'(exp_en), `HD_RESP_OKAY);
    cfg_read(`HD_REG_IRQ_STATUS, 32'(exp_status), `HD_RESP_OKAY);
  endtask

  task automatic check_reset_state();
    // Two synchronizer edges and one spare
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_eq("b_valid_o", 32'(b_valid_o), 32'd0);
    check_eq("r_valid_o", 32'(r_valid_o), 32'd0);
    check_eq("pmu_irq_o", 32'(pmu_irq_o), 32'd0);
    check_eq("dma_pe_evt_o", 32'(dma_pe_evt_o), 32'd0);
    check_eq("dma_pe_evt_ack_o", 32'(dma_pe_evt_ack_o), 32'd0);
    check_eq("aw_ready_o", 32'(aw_ready_o), 32'd1);
    check_eq("ar_ready_o", 32'(ar_ready_o), 32'd1);
    check_all_regs('0);
  endtask

  task automatic count_masked_events();
    logic [31:0] rnd;
    rnd    = $random(seed);
    exp_en = rnd[`HD_NUM_COUNTERS-1:0];
    cfg_write(`HD_REG_ENABLE, 32'(exp_en), `HD_RESP_OKAY);
    for (int c = 0; c < EVT_CYCLES; c++) begin
      rnd = $random(seed);
      @(posedge clk_i);
      llc_read_hit_i   <= rnd[`HD_EVT_RD_HIT];
      llc_read_miss_i  <= rnd[`HD_EVT_RD_MISS];
      llc_write_hit_i  <= rnd[`HD_EVT_WR_HIT];
      llc_write_miss_i <= rnd[`HD_EVT_WR_MISS];
      for (int i = 0; i <= `HD_EVT_WR_MISS; i++) begin
        if (exp_en[i] && rnd[i]) begin
          exp_cnt[i] = exp_cnt[i] + 32'd1;
        end
      end
    end
    @(posedge clk_i);
    llc_read_hit_i   <= 1'b0;
    llc_read_miss_i  <= 1'b0;
    llc_write_hit_i  <= 1'b0;
    llc_write_miss_i <= 1'b0;
    for (int i = 0; i < `HD_NUM_COUNTERS; i++) begin
      cfg_read(cnt_addr(i), exp_cnt[i], `HD_RESP_OKAY);
    end
  endtask

  // Four-phase level handshake as the cluster drives it
  task automatic dma_handshake();
    @(posedge clk_i);
    dma_pe_evt_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!dma_pe_evt_ack_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    dma_pe_evt_valid_i <= 1'b0;
    @(negedge clk_i);
    while (dma_pe_evt_ack_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic cross_dma_events();
    int start;
    exp_en = evt_vec_t'(1) << `HD_EVT_DMA;
    cfg_write(`HD_REG_ENABLE, 32'(exp_en), `HD_RESP_OKAY);
    start = pulse_cnt;
    for (int n = 0; n < NUM_DMA_HS; n++) begin
      dma_handshake();
    end
    repeat (2) @(posedge clk_i);
    check_eq("dma_pe_evt_o pulses", 32'(pulse_cnt - start), 32'(NUM_DMA_HS));
    exp_cnt[`HD_EVT_DMA] = exp_cnt[`HD_EVT_DMA] + 32'(NUM_DMA_HS);
    cfg_read(cnt_addr(`HD_EVT_DMA), exp_cnt[`HD_EVT_DMA], `HD_RESP_OKAY);
  endtask

  task automatic overflow_and_irq();
    evt_vec_t ovf_bit;
    ovf_bit = evt_vec_t'(1) << `HD_EVT_RD_MISS;
    exp_en  = ovf_bit;
    cfg_write(`HD_REG_ENABLE, 32'(exp_en), `HD_RESP_OKAY);
    cfg_write(cnt_addr(`HD_EVT_RD_MISS), 32'hffff_ffff, `HD_RESP_OKAY);
    @(posedge clk_i);
    llc_read_miss_i <= 1'b1;
    @(posedge clk_i);
    llc_read_miss_i <= 1'b0;
    @(negedge clk_i);
    check_eq("pmu_irq_o", 32'(pmu_irq_o), 32'd1);
    // Wrapped from all ones
    exp_cnt[`HD_EVT_RD_MISS] = '0;
    cfg_read(cnt_addr(`HD_EVT_RD_MISS), exp_cnt[`HD_EVT_RD_MISS], `HD_RESP_OKAY);
    cfg_read(`HD_REG_IRQ_STATUS, 32'(ovf_bit), `HD_RESP_OKAY);
    cfg_write(`HD_REG_IRQ_STATUS, 32'(ovf_bit), `HD_RESP_OKAY);
    @(negedge clk_i);
    check_eq("pmu_irq_o", 32'(pmu_irq_o), 32'd0);
    cfg_read(`HD_REG_IRQ_STATUS, 32'd0, `HD_RESP_OKAY);
  endtask

  task automatic unmapped_access();
    evt_vec_t ovf_bit;
    // Status bit set beforehand so a stray clear would show
    ovf_bit = evt_vec_t'(1) << `HD_EVT_RD_MISS;
    cfg_write(cnt_addr(`HD_EVT_RD_MISS), 32'hffff_ffff, `HD_RESP_OKAY);
    @(posedge clk_i);
    llc_read_miss_i <= 1'b1;
    @(posedge clk_i);
    llc_read_miss_i <= 1'b0;
    exp_cnt[`HD_EVT_RD_MISS] = '0;
    cfg_read(32'h0000_0040, `HD_UNMAPPED_RDATA, `HD_RESP_SLVERR);
    cfg_write(32'h0000_0040, 32'hffff_ffff, `HD_RESP_SLVERR);
    check_all_regs(ovf_bit);
  endtask

  task automatic write_backpressure();
    lite_data_t data;
    data = $random(seed);
    @(posedge clk_i);
    b_ready_i <= 1'b0;
    send_write(cnt_addr(`HD_EVT_WR_HIT), data);
    exp_cnt[`HD_EVT_WR_HIT] = data;
    repeat (5) begin
      @(negedge clk_i);
      check_eq("b_valid_o", 32'(b_valid_o), 32'd1);
      check_eq("aw_ready_o", 32'(aw_ready_o), 32'd0);
      check_eq("w_ready_o", 32'(w_ready_o), 32'd0);
    end
    check_eq("b_resp_o", 32'(b_resp_o), 32'(`HD_RESP_OKAY));
    @(posedge clk_i);
    b_ready_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_eq("b_valid_o", 32'(b_valid_o), 32'd0);
    check_eq("aw_ready_o", 32'(aw_ready_o), 32'd1);
    check_eq("w_ready_o", 32'(w_ready_o), 32'd1);
    cfg_read(cnt_addr(`HD_EVT_WR_HIT), exp_cnt[`HD_EVT_WR_HIT], `HD_RESP_OKAY);
  endtask

  initial begin
    seed               = 32'h5275;
    pulse_cnt          = 0;
    clk_i              = 1'b0;
    rst_n_i            = 1'b0;
    llc_read_hit_i     = 1'b0;
    llc_read_miss_i    = 1'b0;
    llc_write_hit_i    = 1'b0;
    llc_write_miss_i   = 1'b0;
    dma_pe_evt_valid_i = 1'b0;
    aw_valid_i         = 1'b0;
    aw_addr_i          = '0;
    w_valid_i          = 1'b0;
    w_data_i           = '0;
    b_ready_i          = 1'b1;
    ar_valid_i         = 1'b0;
    ar_addr_i          = '0;
    r_ready_i          = 1'b1;
    exp_en             = '0;
    for (int i = 0; i < `HD_NUM_COUNTERS; i++) begin
      exp_cnt[i] = '0;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    check_reset_state();
    count_masked_events();
    cross_dma_events();
    overflow_and_irq();
    unmapped_access();
    write_backpressure();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== host_domain.f ====
+incdir+.
host_domain_pkg.sv
rst_sync.sv
edge_propagator_rx.sv
pmu_counters.sv
lite_cfg_port.sv
host_domain.sv
host_domain_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; pass only if the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module host_domain_tb -f host_domain.f

status=0
out=$(./obj_dir/Vhost_domain_tb 2>&1) || status=$?
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
  exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1
